/* hdl/irq_cfg.svh */
`ifndef IRQ_CFG_SVH
`define IRQ_CFG_SVH

// --------------------------------------------------------------------------
// Interrupt lines
// --------------------------------------------------------------------------

// Number of interrupt lines seen by the controller
`define IRQ_NUM 32

// Lines that exist: 3, 7, 11 and 16 to 31
`define IRQ_VALID_MASK 32'hffff_0888

// --------------------------------------------------------------------------
// CSR map
// --------------------------------------------------------------------------

`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MIP     12'h344

// Bit positions inside the mstatus word
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

// --------------------------------------------------------------------------
// Sleep control
// --------------------------------------------------------------------------

// Idle bus cycles needed before the core is put to sleep
`define WFI_SLEEP_LATENCY 2

`endif

/* hdl/irq_pkg.sv */
`include "irq_cfg.svh"

package irq_pkg;

  // --------------------------------------------------------------------------
  // Interrupt vectors
  // --------------------------------------------------------------------------

  // One bit per interrupt line
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Number of a single interrupt line
  typedef logic [$clog2(`IRQ_NUM)-1:0] irq_id_t;

  // --------------------------------------------------------------------------
  // CSR port
  // --------------------------------------------------------------------------

  // 12-bit CSR address space as in RISC-V
  typedef logic [11:0] csr_addr_t;

  // CSR data word
  typedef logic [31:0] csr_data_t;

  // --------------------------------------------------------------------------
  // WFI sleep controller
  // --------------------------------------------------------------------------

  // SLEEP_IDLE    no WFI outstanding
  // SLEEP_DRAIN   WFI accepted, waiting for the bus to stay idle
  // SLEEP_ASLEEP  core clock may be gated
  // SLEEP_DONE    WFI retired towards the core
  typedef enum logic [1:0] {
    SLEEP_IDLE   = 2'd0,
    SLEEP_DRAIN  = 2'd1,
    SLEEP_ASLEEP = 2'd2,
    SLEEP_DONE   = 2'd3
  } sleep_state_e;

endpackage

/* hdl/irq_csr.sv */
`timescale 1ns/1ps

`include "irq_cfg.svh"

module irq_csr (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Raw interrupt lines from the platform
  input  irq_pkg::irq_vec_t   irq_i,

  // CSR access port
  input  logic                csr_we_i,
  input  irq_pkg::csr_addr_t  csr_addr_i,
  input  irq_pkg::csr_data_t  csr_wdata_i,
  output irq_pkg::csr_data_t  csr_rdata_o,

  // Trap entry and return
  input  logic                take_i,
  input  logic                mret_i,

  // To arbiter and sleep controller
  output irq_pkg::irq_vec_t   pend_en_o,
  output logic                glob_en_o
);

  import irq_pkg::*;

  irq_vec_t  mip_q;
  irq_vec_t  mie_q;
  logic      mstatus_mie_q;
  logic      mstatus_mpie_q;

  logic      wr_mstatus;
  logic      wr_mie;
  csr_data_t mstatus_word;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  // mip is read only, so no decode for it
  assign wr_mstatus = csr_we_i && (csr_addr_i == `CSR_MSTATUS);
  assign wr_mie     = csr_we_i && (csr_addr_i == `CSR_MIE);

  // --------------------------------------------------------------------------
  // Pending and enable registers
  // --------------------------------------------------------------------------

  // Inputs are captured one cycle late, reserved lines stay zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
      mie_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
      if (wr_mie) begin
        mie_q <= csr_wdata_i & `IRQ_VALID_MASK;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Status bits
  // --------------------------------------------------------------------------

  // Trap entry beats return, and both beat a software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (take_i) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (wr_mstatus) begin
      mstatus_mie_q  <= csr_wdata_i[`MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[`MSTATUS_MPIE_BIT];
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------

  // Only MIE and MPIE exist in the status word
  always_comb begin
    mstatus_word                    = '0;
    mstatus_word[`MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_word[`MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  always_comb begin
    case (csr_addr_i)
      `CSR_MSTATUS: csr_rdata_o = mstatus_word;
      `CSR_MIE:     csr_rdata_o = mie_q;
      `CSR_MIP:     csr_rdata_o = mip_q;
      default:      csr_rdata_o = '0;
    endcase
  end

  // Lines that are both pending and locally enabled
  assign pend_en_o = mip_q & mie_q;
  assign glob_en_o = mstatus_mie_q;

endmodule

/* hdl/irq_arbiter.sv */
`timescale 1ns/1ps

`include "irq_cfg.svh"

module irq_arbiter (
  // Pending and enabled lines from the CSR block
  input  irq_pkg::irq_vec_t pend_en_i,
  input  logic              glob_en_i,

  // Interrupt handshake with the core
  input  logic              irq_ready_i,
  output logic              irq_valid_o,
  output irq_pkg::irq_id_t  irq_id_o,

  // Handshake completed
  output logic              take_o
);

  import irq_pkg::*;

  irq_id_t winner;
  logic    any_pending;

  // --------------------------------------------------------------------------
  // Fixed priority selection
  // --------------------------------------------------------------------------

  // Lowest priority is checked first so that later hits override it.
  // Resulting order is 31 down to 16, then 11, then 3, then 7
  always_comb begin
    winner = '0;
    if (pend_en_i[7]) begin
      winner = irq_id_t'(7);
    end
    if (pend_en_i[3]) begin
      winner = irq_id_t'(3);
    end
    if (pend_en_i[11]) begin
      winner = irq_id_t'(11);
    end
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en_i[i]) begin
        winner = irq_id_t'(i);
      end
    end
  end

  assign any_pending = |pend_en_i;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Level request, may drop without a transfer
  assign irq_valid_o = any_pending && glob_en_i;
  assign irq_id_o    = winner;

  // Clears MIE in the CSR block, so valid falls after a transfer
  assign take_o      = irq_valid_o && irq_ready_i;

endmodule

/* hdl/wfi_sleep_ctrl.sv */
`timescale 1ns/1ps

`include "irq_cfg.svh"

module wfi_sleep_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Wake sources
  input  irq_pkg::irq_vec_t pend_en_i,
  input  logic              debug_req_i,

  // No outstanding bus transactions
  input  logic              bus_idle_i,

  // WFI handshake with the core
  input  logic              wfi_valid_i,
  output logic              wfi_ready_o,

  // Sleep indication for clock gating
  output logic              core_sleep_o
);

  import irq_pkg::*;

  localparam int unsigned cnt_w = $clog2(`WFI_SLEEP_LATENCY + 1);

  sleep_state_e     state_q;
  sleep_state_e     state_d;
  logic [cnt_w-1:0] drain_cnt_q;
  logic [cnt_w-1:0] drain_cnt_d;
  logic             wake;
  logic             drain_last;

  // Wake ignores the global enable on purpose, as WFI in RISC-V does
  assign wake = (|pend_en_i) || debug_req_i;

  // Idle edge that would bring the counter up to the latency
  assign drain_last = (drain_cnt_q == cnt_w'(`WFI_SLEEP_LATENCY - 1));

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    state_d     = state_q;
    drain_cnt_d = drain_cnt_q;

    case (state_q)
      SLEEP_IDLE: begin
        if (wfi_valid_i) begin
          state_d     = SLEEP_DRAIN;
          drain_cnt_d = '0;
        end
      end

      SLEEP_DRAIN: begin
        if (wake) begin
          state_d     = SLEEP_DONE;
          drain_cnt_d = '0;
        end else if (!bus_idle_i) begin
          // Any busy cycle restarts the drain
          drain_cnt_d = '0;
        end else if (drain_last) begin
          state_d     = SLEEP_ASLEEP;
          drain_cnt_d = '0;
        end else begin
          drain_cnt_d = drain_cnt_q + 1'b1;
        end
      end

      SLEEP_ASLEEP: begin
        if (wake) begin
          state_d = SLEEP_DONE;
        end
      end

      SLEEP_DONE: begin
        // One cycle of ready retires the WFI
        state_d = SLEEP_IDLE;
      end

      default: begin
        state_d     = SLEEP_IDLE;
        drain_cnt_d = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // State registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SLEEP_IDLE;
      drain_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      drain_cnt_q <= drain_cnt_d;
    end
  end

  assign wfi_ready_o  = (state_q == SLEEP_DONE);
  assign core_sleep_o = (state_q == SLEEP_ASLEEP);

endmodule

/* hdl/irq_ctrl_top.sv */
`timescale 1ns/1ps

module irq_ctrl_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Interrupt lines
  input  irq_pkg::irq_vec_t   irq_i,

  // CSR port
  input  logic                csr_we_i,
  input  irq_pkg::csr_addr_t  csr_addr_i,
  input  irq_pkg::csr_data_t  csr_wdata_i,
  output irq_pkg::csr_data_t  csr_rdata_o,

  // Return from trap
  input  logic                mret_i,

  // Interrupt handshake
  input  logic                irq_ready_i,
  output logic                irq_valid_o,
  output irq_pkg::irq_id_t    irq_id_o,

  // WFI handshake and sleep
  input  logic                wfi_valid_i,
  output logic                wfi_ready_o,
  input  logic                bus_idle_i,
  input  logic                debug_req_i,
  output logic                core_sleep_o
);

  import irq_pkg::*;

  irq_vec_t pend_en;
  logic     glob_en;
  logic     take;

  // --------------------------------------------------------------------------
  // CSR registers
  // --------------------------------------------------------------------------

  irq_csr u_irq_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_i       (irq_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .take_i      (take),
    .mret_i      (mret_i),
    .pend_en_o   (pend_en),
    .glob_en_o   (glob_en)
  );

  // --------------------------------------------------------------------------
  // Arbitration and handshake
  // --------------------------------------------------------------------------

  irq_arbiter u_irq_arbiter (
    .pend_en_i   (pend_en),
    .glob_en_i   (glob_en),
    .irq_ready_i (irq_ready_i),
    .irq_valid_o (irq_valid_o),
    .irq_id_o    (irq_id_o),
    .take_o      (take)
  );

  // --------------------------------------------------------------------------
  // WFI sleep
  // --------------------------------------------------------------------------

  wfi_sleep_ctrl u_wfi_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pend_en_i    (pend_en),
    .debug_req_i  (debug_req_i),
    .bus_idle_i   (bus_idle_i),
    .wfi_valid_i  (wfi_valid_i),
    .wfi_ready_o  (wfi_ready_o),
    .core_sleep_o (core_sleep_o)
  );

endmodule

/* testbench/irq_ctrl_properties.sv */
`timescale 1ns/1ps

`include "irq_cfg.svh"

module irq_ctrl_properties (
  input logic              clk_i,
  input logic              rst_ni,
  input irq_pkg::irq_vec_t pend_en_i,
  input logic              irq_valid_i,
  input logic              irq_ready_i,
  input irq_pkg::irq_id_t  irq_id_i,
  input logic              wfi_ready_i,
  input logic              core_sleep_i
);

  import irq_pkg::*;

  localparam irq_vec_t valid_mask = `IRQ_VALID_MASK;

  logic transfer;

  assign transfer = irq_valid_i && irq_ready_i;

  // --------------------------------------------------------------------------
  // Interrupt handshake
  // --------------------------------------------------------------------------

  // A transfer clears MIE, so the next cycle cannot transfer again
  property p_no_back_to_back;
    @(posedge clk_i) disable iff (!rst_ni)
      transfer |=> !transfer;
  endproperty

  // Winner is an existing line that is really pending
  property p_id_is_pending_line;
    @(posedge clk_i) disable iff (!rst_ni)
      irq_valid_i |-> (valid_mask[irq_id_i] && pend_en_i[irq_id_i]);
  endproperty

  // --------------------------------------------------------------------------
  // Sleep
  // --------------------------------------------------------------------------

  // Pending lines are registered, the FSM leaves ASLEEP on the following edge
  property p_sleep_ends_on_pending;
    @(posedge clk_i) disable iff (!rst_ni)
      (core_sleep_i && (|pend_en_i)) |=> !core_sleep_i;
  endproperty

  property p_ready_single_pulse;
    @(posedge clk_i) disable iff (!rst_ni)
      wfi_ready_i |=> !wfi_ready_i;
  endproperty

  a_no_back_to_back : assert property (p_no_back_to_back)
    else $error("Interrupt transferred in two cycles in a row");
  a_id_is_pending_line : assert property (p_id_is_pending_line)
    else $error("irq_id_o is not a pending valid line while irq_valid_o is high");
  a_sleep_ends_on_pending : assert property (p_sleep_ends_on_pending)
    else $error("core_sleep_o stayed high with an enabled interrupt pending");
  a_ready_single_pulse : assert property (p_ready_single_pulse)
    else $error("wfi_ready_o high for two cycles in a row");

endmodule

/* testbench/tb_irq_ctrl.sv */
`timescale 1ns/1ps

`include "irq_cfg.svh"

module tb_irq_ctrl;

  import irq_pkg::*;

  localparam int clk_period   = 40;
  localparam int rst_cycles   = 10;
  localparam int csr_cycles   = 800;
  localparam int sleep_cycles = 1500;
  localparam int mixed_cycles = 1000;
  localparam int timeout_ns   =
    (rst_cycles + csr_cycles + sleep_cycles + mixed_cycles + 100) * clk_period;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  irq_vec_t  irq_i;
  logic      csr_we_i;
  csr_addr_t csr_addr_i;
  csr_data_t csr_wdata_i;
  csr_data_t csr_rdata_o;
  logic      mret_i;
  logic      irq_ready_i;
  logic      irq_valid_o;
  irq_id_t   irq_id_o;
  logic      wfi_valid_i;
  logic      wfi_ready_o;
  logic      bus_idle_i;
  logic      debug_req_i;
  logic      core_sleep_o;

  integer    seed;

  // Reference model state
  irq_vec_t     m_mip;
  irq_vec_t     m_mie;
  logic         m_mie_bit;
  logic         m_mpie_bit;
  sleep_state_e m_state;
  int unsigned  m_cnt;
  logic         done_seen;
  int unsigned  n_take;
  int unsigned  n_sleep;
  int unsigned  n_wake;

  irq_ctrl_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .mret_i       (mret_i),
    .irq_ready_i  (irq_ready_i),
    .irq_valid_o  (irq_valid_o),
    .irq_id_o     (irq_id_o),
    .wfi_valid_i  (wfi_valid_i),
    .wfi_ready_o  (wfi_ready_o),
    .bus_idle_i   (bus_idle_i),
    .debug_req_i  (debug_req_i),
    .core_sleep_o (core_sleep_o)
  );

  bind irq_ctrl_top irq_ctrl_properties u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pend_en_i    (pend_en),
    .irq_valid_i  (irq_valid_o),
    .irq_ready_i  (irq_ready_i),
    .irq_id_i     (irq_id_o),
    .wfi_ready_i  (wfi_ready_o),
    .core_sleep_i (core_sleep_o)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Random helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic chance(int unsigned pct);
    logic [31:0] r;
    r = rand_word();
    return (r % 32'd100) < pct;
  endfunction

  // Priority list 31..16, 11, 3, 7 walked from the top
  function automatic irq_id_t pick_winner(irq_vec_t pend);
    int k;
    int line;
    for (k = 0; k < 19; k++) begin
      line = (k < 16) ? 31 - k : (k == 16) ? 11 : (k == 17) ? 3 : 7;
      if (pend[line]) return irq_id_t'(line);
    end
    return '0;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model, advanced once per rising edge
  // --------------------------------------------------------------------------

  task automatic model_step();
    irq_vec_t pend;
    logic     take;
    logic     wake;
    pend      = m_mip & m_mie;
    take      = (|pend) && m_mie_bit && irq_ready_i;
    wake      = (|pend) || debug_req_i;
    done_seen = (m_state == SLEEP_DONE);

    case (m_state)
      SLEEP_IDLE: begin
        if (wfi_valid_i) begin
          m_state = SLEEP_DRAIN;
          m_cnt   = 0;
        end
      end
      SLEEP_DRAIN: begin
        if (wake) begin
          m_state = SLEEP_DONE;
          n_wake++;
        end else if (!bus_idle_i) begin
          m_cnt = 0;
        end else begin
          m_cnt++;
          if (m_cnt == `WFI_SLEEP_LATENCY) begin
            m_state = SLEEP_ASLEEP;
            m_cnt   = 0;
            n_sleep++;
          end
        end
      end
      SLEEP_ASLEEP: begin
        if (wake) begin
          m_state = SLEEP_DONE;
          n_wake++;
        end
      end
      default: m_state = SLEEP_IDLE;
    endcase

    // Trap entry first, then return, then a software write
    if (take) begin
      m_mpie_bit = m_mie_bit;
      m_mie_bit  = 1'b0;
      n_take++;
    end else if (mret_i) begin
      m_mie_bit  = m_mpie_bit;
      m_mpie_bit = 1'b1;
    end else if (csr_we_i && csr_addr_i == `CSR_MSTATUS) begin
      m_mie_bit  = csr_wdata_i[`MSTATUS_MIE_BIT];
      m_mpie_bit = csr_wdata_i[`MSTATUS_MPIE_BIT];
    end
    if (csr_we_i && csr_addr_i == `CSR_MIE) begin
      m_mie = csr_wdata_i & `IRQ_VALID_MASK;
    end
    m_mip = irq_i & `IRQ_VALID_MASK;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and checks
  // --------------------------------------------------------------------------

  task automatic drive_inputs(int unsigned irq_pct, int unsigned csr_pct,
                              int unsigned ready_pct, int unsigned mret_pct,
                              int unsigned wfi_pct, int unsigned idle_pct,
                              int unsigned dbg_pct);
    logic [31:0] r;
    r = rand_word();
    irq_i       <= chance(irq_pct) ? rand_word() : '0;
    csr_we_i    <= chance(csr_pct);
    csr_wdata_i <= rand_word();
    case (r[1:0])
      2'd0:    csr_addr_i <= `CSR_MSTATUS;
      2'd1:    csr_addr_i <= `CSR_MIE;
      2'd2:    csr_addr_i <= `CSR_MIP;
      default: csr_addr_i <= r[13:2];
    endcase
    irq_ready_i <= chance(ready_pct);
    mret_i      <= chance(mret_pct);
    bus_idle_i  <= chance(idle_pct);
    debug_req_i <= chance(dbg_pct);
    // WFI stays requested until the ready pulse has been seen
    if (wfi_valid_i) begin
      if (done_seen) wfi_valid_i <= 1'b0;
    end else if (chance(wfi_pct)) begin
      wfi_valid_i <= 1'b1;
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "Output check failed");
    end
  endtask

  task automatic check_outputs();
    irq_vec_t  exp_pend;
    csr_data_t exp_rdata;
    exp_pend = m_mip & m_mie;
    case (csr_addr_i)
      `CSR_MSTATUS: begin
        exp_rdata                    = '0;
        exp_rdata[`MSTATUS_MIE_BIT]  = m_mie_bit;
        exp_rdata[`MSTATUS_MPIE_BIT] = m_mpie_bit;
      end
      `CSR_MIE: exp_rdata = m_mie;
      `CSR_MIP: exp_rdata = m_mip;
      default:  exp_rdata = '0;
    endcase
    check_value("csr_rdata_o", csr_rdata_o, exp_rdata);
    check_value("irq_valid_o", 32'(irq_valid_o), 32'((|exp_pend) && m_mie_bit));
    check_value("irq_id_o", 32'(irq_id_o), 32'(pick_winner(exp_pend)));
    check_value("wfi_ready_o", 32'(wfi_ready_o), 32'(m_state == SLEEP_DONE));
    check_value("core_sleep_o", 32'(core_sleep_o), 32'(m_state == SLEEP_ASLEEP));
  endtask

  task automatic run_phase(int unsigned cycles, int unsigned irq_pct,
                           int unsigned csr_pct, int unsigned ready_pct,
                           int unsigned mret_pct, int unsigned wfi_pct,
                           int unsigned idle_pct, int unsigned dbg_pct);
    repeat (cycles) begin
      @(posedge clk_i);
      model_step();
      drive_inputs(irq_pct, csr_pct, ready_pct, mret_pct, wfi_pct, idle_pct, dbg_pct);
      @(negedge clk_i);
      check_outputs();
    end
  endtask

  initial begin
    seed        = 32'hb7b98171;
    rst_ni      = 1'b0;
    irq_i       = '0;
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    mret_i      = 1'b0;
    irq_ready_i = 1'b0;
    wfi_valid_i = 1'b0;
    bus_idle_i  = 1'b1;
    debug_req_i = 1'b0;
    m_mip       = '0;
    m_mie       = '0;
    m_mie_bit   = 1'b0;
    m_mpie_bit  = 1'b0;
    m_state     = SLEEP_IDLE;
    m_cnt       = 0;
    done_seen   = 1'b0;
    n_take      = 0;
    n_sleep     = 0;
    n_wake      = 0;

    repeat (rst_cycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    // CSR access and arbitration, then WFI sleep, then everything at once
    run_phase(csr_cycles, 60, 30, 40, 10, 0, 100, 0);
    run_phase(sleep_cycles, 3, 5, 30, 5, 30, 85, 2);
    run_phase(mixed_cycles, 25, 20, 50, 10, 40, 70, 5);

    if (n_take > 0 && n_sleep > 0 && n_wake > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Stimulus never completed an interrupt, a sleep or a wake-up");
      $display("Verification failed");
      $fatal(1, "Incomplete stimulus");
    end
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Simulation did not finish within %0d ns", timeout_ns);
    $display("Verification failed");
    $fatal(1, "Watchdog timeout");
  end

endmodule

/* irq_ctrl_top.f */
+incdir+hdl
hdl/irq_pkg.sv
hdl/irq_csr.sv
hdl/irq_arbiter.sv
hdl/wfi_sleep_ctrl.sv
hdl/irq_ctrl_top.sv
testbench/irq_ctrl_properties.sv
testbench/tb_irq_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
rm -f "$log_file"

# A failed build or a simulator abort also counts as a failed run
verilator --binary --timing --assert -j 0 \
  --top-module tb_irq_ctrl \
  -f irq_ctrl_top.f \
  -o tb_irq_ctrl > "$log_file" 2>&1 \
  && ./obj_dir/tb_irq_ctrl >> "$log_file" 2>&1 \
  || echo "Verification failed" >> "$log_file"

cat "$log_file"

if grep -q "Verification failed" "$log_file"; then
  exit 1
fi
exit 0
